//--- Bender.yml
package:
  name: frv_pipeline

sources:
  - files:
      - source/frv_pkg.sv
      - source/frv_fetch.sv
      - source/frv_decode.sv
      - source/frv_forward.sv
      - source/frv_execute.sv
      - source/frv_writeback.sv
      - source/frv_gprs.sv
      - source/frv_pipeline.sv
  - target: test
    files:
      - verification/frv_pipeline_tb.sv

//--- compile.f
source/frv_pkg.sv
source/frv_fetch.sv
source/frv_decode.sv
source/frv_forward.sv
source/frv_execute.sv
source/frv_writeback.sv
source/frv_gprs.sv
source/frv_pipeline.sv
verification/frv_pipeline_tb.sv

//--- source/frv_decode.sv
/*
 * Decode stage. Turns the fetched word into a micro-op with its immediate,
 * takes forwarded operands and loads the decode-to-execute register.
 */
`timescale 1ns/1ps

module frv_decode import frv_pkg::*; (
    input  logic      g_clk,                   // Global clock
    input  logic      reset,                   // Synchronous reset
    input  logic      s1_valid,                // Word present
    input  word_t     s1_pc,                   // Its pc
    input  instr_u    s1_instr,                // Word to decode
    output logic      s1_busy,                 // Cannot take the word
    output reg_addr_t s1_rs1,                  // Source index 1
    output reg_addr_t s1_rs2,                  // Source index 2
    input  word_t     opr_a,                   // Forwarded rs1 value
    input  word_t     opr_b,                   // Forwarded rs2 value
    input  logic      flush,                   // Control flow change
    input  logic      s2_busy,                 // Execute stalled
    output logic      s2_valid,                // Register holds an op
    output dec_op_t   s2_op                    // Decoded op
);

    uop_e      uop;
    word_t     imm;
    logic      use_imm;                        // Operand B is the immediate
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;

    // Immediates
    // --------------------------------------------------
    assign imm_i = {{20{s1_instr.i.imm[11]}}, s1_instr.i.imm};
    assign imm_b = {{20{s1_instr.b.imm12}}, s1_instr.b.imm11, s1_instr.b.imm10_5,
                    s1_instr.b.imm4_1, 1'b0};
    assign imm_u = {s1_instr[31:12], 12'b0};
    assign imm_j = {{12{s1_instr[31]}}, s1_instr[19:12], s1_instr[20],
                    s1_instr[30:21], 1'b0};

    assign s1_rs1  = s1_instr.r.rs1;
    assign s1_rs2  = s1_instr.r.rs2;
    assign s1_busy = s2_valid && s2_busy;
    assign rd      = (uop == UOP_NOP) ? '0 : s1_instr.r.rd;    // NOP never writes

    always_comb begin
        uop     = UOP_NOP;                     // Anything unknown
        imm     = imm_i;
        use_imm = 1'b0;
        case (s1_instr.r.opcode)
            OPC_LUI: begin
                uop     = UOP_LUI;
                imm     = imm_u;
                use_imm = 1'b1;
            end
            OPC_OP_IMM: begin
                if (s1_instr.i.funct3 == 3'b000) begin
                    uop     = UOP_ADD;         // ADDI
                    use_imm = 1'b1;
                end
            end
            OPC_OP: begin
                if (s1_instr.r.funct7 == 7'b0100000) begin
                    if (s1_instr.r.funct3 == 3'b000) begin
                        uop = UOP_SUB;
                    end
                end else if (s1_instr.r.funct7 == 7'b0000000) begin
                    case (s1_instr.r.funct3)
                        3'b000:  uop = UOP_ADD;
                        3'b010:  uop = UOP_SLT;
                        3'b100:  uop = UOP_XOR;
                        3'b110:  uop = UOP_OR;
                        3'b111:  uop = UOP_AND;
                        default: uop = UOP_NOP;
                    endcase
                end
            end
            OPC_BRANCH: begin
                imm = imm_b;
                if (s1_instr.b.funct3 == 3'b000) begin
                    uop = UOP_BEQ;
                end else if (s1_instr.b.funct3 == 3'b001) begin
                    uop = UOP_BNE;
                end
            end
            OPC_JAL: begin
                uop = UOP_JAL;
                imm = imm_j;
            end
            default: uop = UOP_NOP;
        endcase
    end

    // Decode to execute register
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (reset || flush) begin
            s2_valid <= 1'b0;
        end else if (!s1_busy) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s1_valid && !s1_busy) begin
            s2_op.pc    <= s1_pc;
            s2_op.instr <= s1_instr;
            s2_op.rd    <= rd;
            s2_op.uop   <= uop;
            s2_op.rs1   <= s1_rs1;
            s2_op.rs2   <= s1_rs2;
            s2_op.imm   <= imm;
            s2_op.opr_a <= opr_a;
            s2_op.opr_b <= use_imm ? imm : opr_b;
        end
    end

endmodule

//--- source/frv_execute.sv
/*
 * Execute stage. ALU for the supported integer ops, branch compare and
 * target add, then the execute-to-writeback register.
 */
`timescale 1ns/1ps

module frv_execute import frv_pkg::*; (
    input  logic    g_clk,                     // Global clock
    input  logic    reset,                     // Synchronous reset
    input  logic    s2_valid,                  // Op present
    input  dec_op_t s2_op,                     // Decoded op
    output logic    s2_busy,                   // Cannot take an op
    input  logic    flush,                     // Control flow change
    output fwd_t    fwd_s2,                    // Result for forwarding
    output logic    s3_valid,                  // Result present
    output ex_res_t s3_res                     // Result record
);

    word_t     result;
    logic      taken;
    logic      eq;
    logic      is_branch;
    reg_addr_t rd_x;

    assign eq        = (s2_op.opr_a == s2_op.opr_b);
    assign is_branch = (s2_op.uop == UOP_BEQ) || (s2_op.uop == UOP_BNE);
    assign rd_x      = is_branch ? '0 : s2_op.rd;      // Branches write nothing
    assign s2_busy   = 1'b0;                           // Writeback takes one per cycle

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (s2_op.uop)
            UOP_ADD: result = s2_op.opr_a + s2_op.opr_b;
            UOP_SUB: result = s2_op.opr_a - s2_op.opr_b;
            UOP_AND: result = s2_op.opr_a & s2_op.opr_b;
            UOP_OR:  result = s2_op.opr_a | s2_op.opr_b;
            UOP_XOR: result = s2_op.opr_a ^ s2_op.opr_b;
            UOP_SLT: result = {{(XLEN-1){1'b0}}, $signed(s2_op.opr_a) < $signed(s2_op.opr_b)};
            UOP_LUI: result = s2_op.opr_b;             // Immediate already in B
            UOP_BEQ: taken = eq;
            UOP_BNE: taken = !eq;
            UOP_JAL: begin
                result = s2_op.pc + 32'd4;             // Link value
                taken  = 1'b1;
            end
            default: result = '0;
        endcase
    end

    assign fwd_s2 = '{valid: s2_valid, rd: rd_x, wdata: result};

    // Execute to writeback register
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (reset || flush) begin
            s3_valid <= 1'b0;
        end else if (!s2_busy) begin
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s2_valid && !s2_busy) begin
            s3_res.pc     <= s2_op.pc;
            s3_res.instr  <= s2_op.instr;
            s3_res.rd     <= rd_x;
            s3_res.wdata  <= result;
            s3_res.taken  <= taken;
            s3_res.target <= s2_op.pc + s2_op.imm;     // Branch and JAL target
        end
    end

endmodule

//--- source/frv_fetch.sv
/*
 * Fetch stage. Issues one instruction-bus request at a time, holds the
 * returned word in a one-entry buffer for decode, and takes the new pc
 * from writeback once the bus has drained.
 */
`timescale 1ns/1ps

module frv_fetch import frv_pkg::*; (
    input  logic   g_clk,                      // Global clock
    input  logic   reset,                      // Synchronous reset
    input  logic   cf_req,                     // Control flow change
    input  word_t  cf_target,                  // Change destination
    output logic   cf_ack,                     // Change taken
    output logic   imem_req,                   // Start request
    output logic   imem_ack,                   // Response accepted
    output word_t  imem_addr,                  // Request address
    input  logic   imem_gnt,                   // Request accepted
    input  logic   imem_recv,                  // Response present
    input  word_t  imem_rdata,                 // Response word
    input  logic   s1_busy,                    // Decode stalled
    output logic   s1_valid,                   // Buffer full
    output word_t  s1_pc,                      // Buffered pc
    output instr_u s1_instr                    // Buffered word
);

    logic  run_q;                              // Set one cycle after reset
    logic  stuck_q;                            // Request left ungranted
    logic  pend_q;                             // Response outstanding
    word_t pc_q;                               // Next fetch address
    word_t rsp_pc_q;                           // Address of pending request
    logic  rsp_take;
    logic  flush;

    assign flush     = cf_req && cf_ack;
    assign rsp_take  = imem_recv && imem_ack;
    assign imem_ack  = pend_q && !(s1_valid && s1_busy);   // Back-pressure holds bus
    assign imem_req  = stuck_q || (run_q && !cf_req && (!pend_q || rsp_take));
    assign imem_addr = pc_q;
    assign cf_ack    = cf_req && !pend_q && !stuck_q;      // Bus must be idle

    always_ff @(posedge g_clk) begin
        if (reset) begin
            run_q    <= 1'b0;
            stuck_q  <= 1'b0;
            pend_q   <= 1'b0;
            pc_q     <= RESET_PC;
            s1_valid <= 1'b0;
        end else begin
            run_q   <= 1'b1;
            stuck_q <= imem_req && !imem_gnt;
            if (imem_req && imem_gnt) begin
                pend_q <= 1'b1;
            end else if (rsp_take) begin
                pend_q <= 1'b0;
            end
            if (flush) begin
                pc_q <= cf_target;                 // Redirect
            end else if (imem_req && imem_gnt) begin
                pc_q <= pc_q + 32'd4;
            end
            if (flush) begin
                s1_valid <= 1'b0;                  // Wrong-path word dropped
            end else if (rsp_take) begin
                s1_valid <= 1'b1;
            end else if (!s1_busy) begin
                s1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (imem_req && imem_gnt) begin
            rsp_pc_q <= pc_q;
        end
        if (rsp_take) begin
            s1_pc    <= rsp_pc_q;
            s1_instr <= imem_rdata;
        end
    end

    // Address may not move under a waiting request
    a_addr_hold: assert property (@(posedge g_clk) disable iff (reset)
        imem_req && !imem_gnt |=> imem_req && $stable(imem_addr));

endmodule

//--- source/frv_forward.sv
/*
 * Operand forwarding for decode. Each source index is compared with the
 * execute and writeback destinations; the youngest match wins, else the
 * register file value is used.
 */
`timescale 1ns/1ps

module frv_forward import frv_pkg::*; (
    input  reg_addr_t rs1,                     // Decode source 1
    input  reg_addr_t rs2,                     // Decode source 2
    input  word_t     rf_rdata1,               // Register file port 1
    input  word_t     rf_rdata2,               // Register file port 2
    input  fwd_t      fwd_s2,                  // Execute result
    input  fwd_t      fwd_s3,                  // Writeback result
    output word_t     opr_a,                   // Operand A
    output word_t     opr_b                    // Operand B
);

    // Execute beats writeback beats the register file
    function automatic word_t fwd_pick(input reg_addr_t rs, input word_t rf_data,
                                       input fwd_t young, input fwd_t old);
        logic nz;
        nz = |rs;                              // x0 never forwarded
        if (nz && young.valid && young.rd == rs) begin
            return young.wdata;
        end
        if (nz && old.valid && old.rd == rs) begin
            return old.wdata;
        end
        return rf_data;
    endfunction

    assign opr_a = fwd_pick(rs1, rf_rdata1, fwd_s2, fwd_s3);
    assign opr_b = fwd_pick(rs2, rf_rdata2, fwd_s2, fwd_s3);

endmodule

//--- source/frv_gprs.sv
/*
 * General purpose register file. Two combinational read ports and one
 * write port. Entry 0 is cleared by reset and never written, so x0 reads
 * as zero.
 */
`timescale 1ns/1ps

module frv_gprs import frv_pkg::*; (
    input  logic      g_clk,                   // Global clock
    input  logic      reset,                   // Synchronous reset
    input  reg_addr_t rs1_addr,                // Read port 1 index
    input  reg_addr_t rs2_addr,                // Read port 2 index
    output word_t     rs1_data,                // Read port 1 data
    output word_t     rs2_data,                // Read port 2 data
    input  logic      rd_wen,                  // Write enable
    input  reg_addr_t rd_addr,                 // Write index
    input  word_t     rd_wdata                 // Write data
);

    word_t regs [32];                          // Entry 0 cleared by reset only

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (reset) begin
            regs[0] <= '0;                     // x0 reads as zero
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    // x0 survives every write
    a_x0_zero: assert property (@(posedge g_clk) disable iff (reset)
        (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0));

endmodule

//--- source/frv_pipeline.sv
/*
 * Top level of the four-stage core. Wires fetch, decode, execute and
 * writeback with the register file and operand forwarding.
 */
`timescale 1ns/1ps

module frv_pipeline import frv_pkg::*; (
    input  logic   g_clk,                      // Global clock
    input  logic   reset,                      // Synchronous reset
    output logic   imem_req,                   // Start request
    output word_t  imem_addr,                  // Request address
    input  logic   imem_gnt,                   // Request accepted
    input  logic   imem_recv,                  // Response present
    output logic   imem_ack,                   // Response accepted
    input  word_t  imem_rdata,                 // Response word
    output logic   trs_valid,                  // Retirement pulse
    output trace_t trs                         // Retirement record
);

    logic      cf_req;                         // Control flow change bus
    logic      cf_ack;
    word_t     cf_target;
    logic      flush;                          // Clears every stage register

    logic      s1_valid;                       // Fetch to decode
    logic      s1_busy;
    word_t     s1_pc;
    instr_u    s1_instr;
    reg_addr_t s1_rs1;
    reg_addr_t s1_rs2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     opr_a;                          // Forwarded operands
    word_t     opr_b;

    logic      s2_valid;                       // Decode to execute
    logic      s2_busy;
    dec_op_t   s2_op;
    fwd_t      fwd_s2;

    logic      s3_valid;                       // Execute to writeback
    ex_res_t   s3_res;
    fwd_t      fwd_s3;

    logic      gpr_wen;                        // Register write port
    reg_addr_t gpr_rd;
    word_t     gpr_wdata;

    assign flush = cf_req && cf_ack;

    // Stages
    // --------------------------------------------------
    frv_fetch i_pipeline_s0_fetch (
        .g_clk, .reset,
        .cf_req, .cf_target, .cf_ack,
        .imem_req, .imem_ack, .imem_addr, .imem_gnt, .imem_recv, .imem_rdata,
        .s1_busy, .s1_valid, .s1_pc, .s1_instr
    );

    frv_decode i_pipeline_s1_decode (
        .g_clk, .reset,
        .s1_valid, .s1_pc, .s1_instr, .s1_busy, .s1_rs1, .s1_rs2,
        .opr_a, .opr_b,
        .flush,
        .s2_busy, .s2_valid, .s2_op
    );

    frv_forward i_forward (
        .rs1       (s1_rs1   ),
        .rs2       (s1_rs2   ),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .fwd_s2, .fwd_s3,
        .opr_a, .opr_b
    );

    frv_execute i_pipeline_s2_execute (
        .g_clk, .reset,
        .s2_valid, .s2_op, .s2_busy,
        .flush,
        .fwd_s2, .s3_valid, .s3_res
    );

    frv_writeback i_pipeline_s3_writeback (
        .g_clk, .reset,
        .s3_valid, .s3_res, .fwd_s3,
        .cf_req, .cf_target, .cf_ack,
        .gpr_wen, .gpr_rd, .gpr_wdata,
        .trs_valid, .trs
    );

    // Register file
    // --------------------------------------------------
    frv_gprs i_gprs (
        .g_clk, .reset,
        .rs1_addr (s1_rs1   ),             // Decode source 1
        .rs2_addr (s1_rs2   ),             // Decode source 2
        .rs1_data (rf_rdata1),
        .rs2_data (rf_rdata2),
        .rd_wen   (gpr_wen  ),
        .rd_addr  (gpr_rd   ),
        .rd_wdata (gpr_wdata)
    );

endmodule

//--- source/frv_pkg.sv
/*
 * Widths, opcodes and pipeline record types shared by the four-stage
 * RISC-V integer core. Every RTL module imports this package in its header.
 */
package frv_pkg;

    // Widths and reset state
    // --------------------------------------------------
    localparam int XLEN       = 32;             // Data and address width
    localparam int REG_ADDR_W = 5;              // Register index width
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR, UOP_SLT,
        UOP_LUI, UOP_BEQ, UOP_BNE, UOP_JAL, UOP_NOP
    } uop_e;

    // Instruction word views
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;                       // Sign bit in imm[11]
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic       imm12;                      // Sign bit
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_b_t b;
    } instr_u;

    // Stage records
    // --------------------------------------------------
    typedef struct packed {
        word_t     pc;
        instr_u    instr;
        reg_addr_t rd;
        uop_e      uop;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;                         // Branch / jump offset
        word_t     opr_a;
        word_t     opr_b;                       // Already swapped for imm ops
    } dec_op_t;

    typedef struct packed {
        word_t     pc;
        instr_u    instr;
        reg_addr_t rd;
        word_t     wdata;
        logic      taken;                       // Redirect fetch on retire
        word_t     target;
    } ex_res_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        word_t     pc;
        word_t     instr;
        reg_addr_t rd;
        word_t     wdata;
    } trace_t;

endpackage

//--- source/frv_writeback.sv
/*
 * Writeback stage. Retires each result into the register file, emits the
 * trace record and raises the control-flow request for taken ops.
 */
`timescale 1ns/1ps

module frv_writeback import frv_pkg::*; (
    input  logic      g_clk,                   // Global clock
    input  logic      reset,                   // Synchronous reset
    input  logic      s3_valid,                // Result present
    input  ex_res_t   s3_res,                  // Result record
    output fwd_t      fwd_s3,                  // Result for forwarding
    output logic      cf_req,                  // Control flow change
    output word_t     cf_target,               // Change destination
    input  logic      cf_ack,                  // Change taken by fetch
    output logic      gpr_wen,                 // Register write
    output reg_addr_t gpr_rd,                  // Destination
    output word_t     gpr_wdata,               // Write data
    output logic      trs_valid,               // Retirement pulse
    output trace_t    trs                      // Retirement record
);

    logic retire;

    // Anything behind a pending redirect is wrong path
    assign retire    = s3_valid && !cf_req;

    assign gpr_wen   = retire;
    assign gpr_rd    = s3_res.rd;
    assign gpr_wdata = s3_res.wdata;
    assign fwd_s3    = '{valid: retire, rd: s3_res.rd, wdata: s3_res.wdata};

    assign trs_valid = retire;
    assign trs       = '{pc: s3_res.pc, instr: s3_res.instr, rd: s3_res.rd,
                         wdata: s3_res.wdata};

    always_ff @(posedge g_clk) begin
        if (reset) begin
            cf_req <= 1'b0;
        end else if (cf_ack) begin
            cf_req <= 1'b0;
        end else if (retire && s3_res.taken) begin
            cf_req <= 1'b1;                    // Held until fetch acks
        end
    end

    always_ff @(posedge g_clk) begin
        if (retire && s3_res.taken) begin
            cf_target <= s3_res.target;
        end
    end

    // Fetch may ack only a raised request
    a_ack_needs_req: assert property (@(posedge g_clk) disable iff (reset)
        cf_ack |-> cf_req);

endmodule

//--- verification/frv_pipeline_tb.sv
/*
 * Testbench for the four-stage core. Models the instruction bus with
 * random grant and response delays, runs a fixed program and compares
 * every retirement record with a hand-worked table.
 */
`timescale 1ns/1ps

module frv_pipeline_tb import frv_pkg::*; ();

    localparam int PROG_LEN     = 25;          // Words in the program table
    localparam int RETIRE_LEN   = 21;          // Entries in the retire table
    localparam int RESET_CYCLES = 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RETIRE_LEN * 40;
    localparam word_t NOP_WORD  = 32'h0000_0013;   // addi x0, x0, 0

    logic   g_clk;
    logic   reset;
    logic   imem_req;
    word_t  imem_addr;
    logic   imem_gnt;
    logic   imem_recv;
    logic   imem_ack;
    word_t  imem_rdata;
    logic   trs_valid;
    trace_t trs;

    word_t  prog     [PROG_LEN];               // Instruction memory contents
    trace_t expected [RETIRE_LEN];             // Retire order, hand-worked
    int     matched;                           // Entries checked so far

    frv_pipeline UUT (
        .g_clk, .reset,
        .imem_req, .imem_addr, .imem_gnt, .imem_recv, .imem_ack, .imem_rdata,
        .trs_valid, .trs
    );

    // Helpers
    // --------------------------------------------------
    task automatic stop_on_failure;
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp_w, input word_t act_w);
        if (act_w !== exp_w) begin
            $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp_w, act_w);
            stop_on_failure();
        end
    endtask

    task automatic check_trace(input int idx, input trace_t exp_t, input trace_t act_t);
        check_word($sformatf("trs.pc[%0d]", idx), exp_t.pc, act_t.pc);
        check_word($sformatf("trs.instr[%0d]", idx), exp_t.instr, act_t.instr);
        if (act_t.rd !== exp_t.rd) begin
            $display("** Error: trs.rd[%0d] expected 0x%02h actual 0x%02h",
                     idx, exp_t.rd, act_t.rd);
            stop_on_failure();
        end
        if (exp_t.rd != '0) begin             // x0 target leaves no state
            check_word($sformatf("trs.wdata[%0d]", idx), exp_t.wdata, act_t.wdata);
        end
    endtask

    function automatic trace_t retire_entry(input word_t off, input word_t instr,
                                            input reg_addr_t rd, input word_t wdata);
        trace_t t;
        t.pc    = RESET_PC + off;
        t.instr = instr;
        t.rd    = rd;
        t.wdata = wdata;
        return t;
    endfunction

    function automatic word_t program_word(input word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off[1:0] == 2'b00 && (off >> 2) < PROG_LEN) begin
            return prog[off >> 2];
        end
        return NOP_WORD;                       // Past the end of the program
    endfunction

    // Program and retire tables
    // --------------------------------------------------
    task automatic load_tables;
        prog[0]  = 32'h1234_50B7;              // lui  x1, 0x12345
        prog[1]  = 32'h0640_0113;              // addi x2, x0, 100
        prog[2]  = 32'hFF91_0193;              // addi x3, x2, -7
        prog[3]  = 32'h0031_0233;              // add  x4, x2, x3
        prog[4]  = 32'h4012_02B3;              // sub  x5, x4, x1
        prog[5]  = 32'h0042_F333;              // and  x6, x5, x4
        prog[6]  = 32'h0020_E3B3;              // or   x7, x1, x2
        prog[7]  = 32'h0053_C433;              // xor  x8, x7, x5
        prog[8]  = 32'h0042_A4B3;              // slt  x9, x5, x4
        prog[9]  = 32'h0052_2533;              // slt  x10, x4, x5
        prog[10] = 32'h0052_0013;              // addi x0, x4, 5
        prog[11] = 32'h0090_05B3;              // add  x11, x0, x9
        prog[12] = 32'h00B4_8663;              // beq  x9, x11, +12 (taken)
        prog[13] = 32'h0010_0613;              // addi x12, x0, 1 (wrong path)
        prog[14] = 32'h0020_0693;              // addi x13, x0, 2 (wrong path)
        prog[15] = 32'h0062_1463;              // bne  x4, x6, +8 (not taken)
        prog[16] = 32'h0020_8463;              // beq  x1, x2, +8 (not taken)
        prog[17] = 32'h00C0_076F;              // jal  x14, +12
        prog[18] = 32'h0030_0793;              // addi x15, x0, 3 (wrong path)
        prog[19] = 32'h0040_0813;              // addi x16, x0, 4 (wrong path)
        prog[20] = 32'h0007_08B3;              // add  x17, x14, x0
        prog[21] = 32'h40E8_8933;              // sub  x18, x17, x14
        prog[22] = 32'h0008_9463;              // bne  x17, x0, +8 (taken)
        prog[23] = 32'h0050_0993;              // addi x19, x0, 5 (wrong path)
        prog[24] = 32'h0000_006F;              // jal  x0, 0

        expected[0]  = retire_entry(32'h00, 32'h1234_50B7, 5'd1,  32'h1234_5000);
        expected[1]  = retire_entry(32'h04, 32'h0640_0113, 5'd2,  32'h0000_0064);
        expected[2]  = retire_entry(32'h08, 32'hFF91_0193, 5'd3,  32'h0000_005D);
        expected[3]  = retire_entry(32'h0C, 32'h0031_0233, 5'd4,  32'h0000_00C1);
        expected[4]  = retire_entry(32'h10, 32'h4012_02B3, 5'd5,  32'hEDCB_B0C1);
        expected[5]  = retire_entry(32'h14, 32'h0042_F333, 5'd6,  32'h0000_00C1);
        expected[6]  = retire_entry(32'h18, 32'h0020_E3B3, 5'd7,  32'h1234_5064);
        expected[7]  = retire_entry(32'h1C, 32'h0053_C433, 5'd8,  32'hFFFF_E0A5);
        expected[8]  = retire_entry(32'h20, 32'h0042_A4B3, 5'd9,  32'h0000_0001);
        expected[9]  = retire_entry(32'h24, 32'h0052_2533, 5'd10, 32'h0000_0000);
        expected[10] = retire_entry(32'h28, 32'h0052_0013, 5'd0,  32'h0000_0000);
        expected[11] = retire_entry(32'h2C, 32'h0090_05B3, 5'd11, 32'h0000_0001);
        expected[12] = retire_entry(32'h30, 32'h00B4_8663, 5'd0,  32'h0000_0000);
        expected[13] = retire_entry(32'h3C, 32'h0062_1463, 5'd0,  32'h0000_0000);
        expected[14] = retire_entry(32'h40, 32'h0020_8463, 5'd0,  32'h0000_0000);
        expected[15] = retire_entry(32'h44, 32'h00C0_076F, 5'd14, 32'h8000_0048);
        expected[16] = retire_entry(32'h50, 32'h0007_08B3, 5'd17, 32'h8000_0048);
        expected[17] = retire_entry(32'h54, 32'h40E8_8933, 5'd18, 32'h0000_0000);
        expected[18] = retire_entry(32'h58, 32'h0008_9463, 5'd0,  32'h0000_0000);
        expected[19] = retire_entry(32'h60, 32'h0000_006F, 5'd0,  32'h0000_0000);
        expected[20] = retire_entry(32'h60, 32'h0000_006F, 5'd0,  32'h0000_0000);
    endtask

    // Clock
    // --------------------------------------------------
    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;             // 4 ns period
    end

    // Instruction bus model, one response outstanding
    // --------------------------------------------------
    initial begin : imem_model
        int unsigned gnt_wait;                 // Cycles before imem_gnt rises
        int unsigned rsp_wait;                 // Cycles before imem_recv rises
        logic        rsp_full;
        logic        in_reset;
        word_t       rsp_word;
        void'($urandom(1));
        imem_gnt   = 1'b0;
        imem_recv  = 1'b0;
        imem_rdata = '0;
        gnt_wait   = 0;
        rsp_wait   = 0;
        rsp_full   = 1'b0;
        rsp_word   = '0;
        forever begin
            @(posedge g_clk);
            in_reset = reset;
            if (in_reset) begin
                rsp_full = 1'b0;
                gnt_wait = $urandom_range(3, 0);
            end else begin
                // Response side first so take and grant can share an edge
                if (imem_recv && imem_ack) begin
                    rsp_full = 1'b0;
                end else if (rsp_full && rsp_wait != 0) begin
                    rsp_wait = rsp_wait - 1;
                end
                if (imem_req && imem_gnt && rsp_full) begin
                    $display("Instruction bus granted while a response was pending");
                    stop_on_failure();
                end else if (imem_req && imem_gnt) begin
                    rsp_full = 1'b1;
                    rsp_word = program_word(imem_addr);
                    rsp_wait = $urandom_range(3, 0);
                    gnt_wait = $urandom_range(3, 0);   // Delay for the next request
                end else if (imem_req && gnt_wait != 0) begin
                    gnt_wait = gnt_wait - 1;
                end
            end
            #1;
            imem_gnt   = !in_reset && (gnt_wait == 0);
            imem_recv  = rsp_full && (rsp_wait == 0);  // Held until acked
            imem_rdata = imem_recv ? rsp_word : '0;
        end
    end

    // Watchdog
    // --------------------------------------------------
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge g_clk);
        $display("Timeout: retirement stalled after %0d of %0d instructions",
                 matched, RETIRE_LEN);
        stop_on_failure();
    end

    // Reset, then walk the retire table
    // --------------------------------------------------
    initial begin : main
        reset   = 1'b1;
        matched = 0;
        load_tables();
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1 reset = 1'b0;
        for (int i = 0; i < RETIRE_LEN; i++) begin
            @(posedge g_clk);
            while (trs_valid !== 1'b1) begin
                @(posedge g_clk);              // Watchdog bounds this
            end
            check_trace(i, expected[i], trs);
            matched = matched + 1;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
